/* verilog/prf_defines.svh */
// ----------------------------------------------------------------------
// Size constants for the banked physical register file.
// Included by the package and by every module that sizes a port or
// an array. The package builds its field types from these.
// ----------------------------------------------------------------------

`ifndef PRF_DEFINES_SVH
`define PRF_DEFINES_SVH

// register file geometry
`define PRF_PR_COUNT    32
`define PRF_BANK_COUNT  4

// requesters competing for the banks
`define PRF_RR_COUNT    3
`define PRF_WR_COUNT    3

// field widths
`define PRF_DATA_W      32
`define PRF_PR_W        5
// low PR bits pick the bank, high bits pick the row
`define PRF_BANK_W      2
`define PRF_UPPER_PR_W  3
`define PRF_ROB_W       5

`endif

/* verilog/prf_pkg.sv */
// ----------------------------------------------------------------------
// Field types and request / bus structs for the register file.
// Modules name these types by scope in their port lists and import
// the package inside the body.
// ----------------------------------------------------------------------

`include "prf_defines.svh"

package prf_pkg;

    typedef logic [`PRF_PR_W-1:0]       pr_t;
    typedef logic [`PRF_UPPER_PR_W-1:0] upper_pr_t;
    typedef logic [`PRF_DATA_W-1:0]     data_t;
    typedef logic [`PRF_ROB_W-1:0]      rob_index_t;

    // read request, just the register to read
    typedef struct packed {
        pr_t pr;
    } rd_req_t;

    // writeback request from an execution pipe
    typedef struct packed {
        pr_t        pr;
        data_t      data;
        rob_index_t rob_index;
    } wb_req_t;

    // per-bank writeback announcement, also drives the RAM write
    typedef struct packed {
        logic      valid;
        upper_pr_t upper_pr;
    } wb_bus_t;

    // per-bank completion to the ROB
    typedef struct packed {
        logic       valid;
        rob_index_t rob_index;
    } complete_t;

endpackage

/* verilog/req_hold.sv */
// ----------------------------------------------------------------------
// Holding stage for one requester. A request that loses arbitration
// is kept here and replayed ahead of new input until it is granted.
// Used by both the read path and the writeback path.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module req_hold #(
    parameter type payload_t = logic
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     in_valid,
    input  payload_t in_payload,
    input  logic     grant,
    output logic     ready,
    output logic     req_valid,
    output payload_t req_payload
);

    logic     held_valid;
    payload_t held_payload;

    // held request wins over anything new
    assign ready       = ~held_valid;
    assign req_valid   = held_valid | in_valid;
    assign req_payload = held_valid ? held_payload : in_payload;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            held_valid <= 1'b0;
        end else begin
            held_valid <= req_valid & ~grant;
        end
    end

    always_ff @(posedge CLK) begin
        if (req_valid && !grant) begin
            held_payload <= req_payload;
        end
    end

    // a losing request is replayed unchanged on the next cycle
    a_hold_stable: assert property (@(posedge CLK) disable iff (!nRST)
        req_valid && !grant |=> held_valid && req_payload == $past(req_payload));

endmodule

/* verilog/bank_arbiter.sv */
// ----------------------------------------------------------------------
// Round-robin arbiter for one bank. The winner is the lowest requester
// above the last winner, else the lowest requester overall. The last
// winner state moves only on a cycle that grants.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module bank_arbiter #(
    parameter int N_REQ = 3
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic [N_REQ-1:0] req,
    output logic [N_REQ-1:0] grant
);

    // set for requesters strictly above the last winner
    logic [N_REQ-1:0] last_mask;
    logic [N_REQ-1:0] next_mask;
    logic [N_REQ-1:0] masked_req;
    logic [N_REQ-1:0] masked_grant;
    logic [N_REQ-1:0] unmasked_grant;

    // lowest set bit by two's complement
    assign masked_req     = req & last_mask;
    assign masked_grant   = masked_req & (~masked_req + N_REQ'(1));
    assign unmasked_grant = req & (~req + N_REQ'(1));
    assign grant          = (|masked_req) ? masked_grant : unmasked_grant;

    // thermometer of everything above this grant
    always_comb begin
        next_mask = '0;
        for (int i = 1; i < N_REQ; i++) begin
            next_mask[i] = next_mask[i-1] | grant[i-1];
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            last_mask <= '0;
        end else if (|grant) begin
            last_mask <= next_mask;
        end
    end

    a_grant_onehot: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(grant));
    a_grant_in_req: assert property (@(posedge CLK) disable iff (!nRST)
        (grant & ~req) == '0);

endmodule

/* verilog/bank_ram.sv */
// ----------------------------------------------------------------------
// Storage for one register bank. One write port, written on the clock
// edge, and one combinational read port. All rows are zero after reset.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "prf_defines.svh"

module bank_ram (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               wen,
    input  prf_pkg::upper_pr_t windex,
    input  prf_pkg::data_t     wdata,
    input  prf_pkg::upper_pr_t rindex,
    output prf_pkg::data_t     rdata
);

    import prf_pkg::*;

    localparam int ROWS = `PRF_PR_COUNT / `PRF_BANK_COUNT;

    data_t mem [ROWS];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < ROWS; i++) begin
                mem[i] <= '0;
            end
        end else if (wen) begin
            mem[windex] <= wdata;
        end
    end

    assign rdata = mem[rindex];

endmodule

/* verilog/prf_read_path.sv */
// ----------------------------------------------------------------------
// Read side of the register file. Each read requester goes through a
// holding stage, then competes for its bank. The granted row per bank
// is registered as the RAM read address and the grant returns as ack.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "prf_defines.svh"

module prf_read_path (
    input  logic                                      CLK,
    input  logic                                      nRST,
    input  logic [`PRF_RR_COUNT-1:0]                  rd_valid,
    input  prf_pkg::rd_req_t [`PRF_RR_COUNT-1:0]      rd_req,
    output logic [`PRF_RR_COUNT-1:0]                  rd_ready,
    output logic [`PRF_RR_COUNT-1:0]                  rd_ack,
    output prf_pkg::upper_pr_t [`PRF_BANK_COUNT-1:0]  rd_rindex
);

    import prf_pkg::*;

    logic [`PRF_RR_COUNT-1:0]                         req_valid;
    rd_req_t [`PRF_RR_COUNT-1:0]                      req_payload;
    logic [`PRF_RR_COUNT-1:0]                         grant_by_rr;
    logic [`PRF_BANK_COUNT-1:0][`PRF_RR_COUNT-1:0]    req_by_bank;
    logic [`PRF_BANK_COUNT-1:0][`PRF_RR_COUNT-1:0]    grant_by_bank;
    upper_pr_t [`PRF_BANK_COUNT-1:0]                  next_rindex;

    // ------------------------------------------------------------------
    // holding and arbitration

    for (genvar r = 0; r < `PRF_RR_COUNT; r++) begin : g_hold
        req_hold #(.payload_t(rd_req_t)) u_hold (
            .CLK         (CLK),
            .nRST        (nRST),
            .in_valid    (rd_valid[r]),
            .in_payload  (rd_req[r]),
            .grant       (grant_by_rr[r]),
            .ready       (rd_ready[r]),
            .req_valid   (req_valid[r]),
            .req_payload (req_payload[r])
        );
    end

    for (genvar b = 0; b < `PRF_BANK_COUNT; b++) begin : g_arb
        bank_arbiter #(.N_REQ(`PRF_RR_COUNT)) u_arb (
            .CLK   (CLK),
            .nRST  (nRST),
            .req   (req_by_bank[b]),
            .grant (grant_by_bank[b])
        );
    end

    // steer each request to the bank in its low PR bits
    always_comb begin
        req_by_bank = '0;
        for (int r = 0; r < `PRF_RR_COUNT; r++) begin
            req_by_bank[req_payload[r].pr[`PRF_BANK_W-1:0]][r] = req_valid[r];
        end
    end

    // ------------------------------------------------------------------
    // grant fold and row select

    always_comb begin
        grant_by_rr = '0;
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            grant_by_rr |= grant_by_bank[b];
            next_rindex[b] = '0;
            for (int r = 0; r < `PRF_RR_COUNT; r++) begin
                next_rindex[b] |= req_payload[r].pr[`PRF_PR_W-1:`PRF_BANK_W]
                    & {`PRF_UPPER_PR_W{grant_by_bank[b][r]}};
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rd_ack <= '0;
        end else begin
            rd_ack <= grant_by_rr;
        end
    end

    // read address holds until the bank grants again
    always_ff @(posedge CLK) begin
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            if (|grant_by_bank[b]) begin
                rd_rindex[b] <= next_rindex[b];
            end
        end
    end

endmodule

/* verilog/prf_wb_path.sv */
// ----------------------------------------------------------------------
// Writeback side of the register file. Writebacks are held, arbitrated
// per bank and muxed by the one-hot grant into registered bus, complete
// and write data outputs. The registered wb_bus also drives the RAM
// write, so a write to PR 0 is dropped while its completion still goes out.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "prf_defines.svh"

module prf_wb_path (
    input  logic                                      CLK,
    input  logic                                      nRST,
    input  logic [`PRF_WR_COUNT-1:0]                  wb_valid,
    input  prf_pkg::wb_req_t [`PRF_WR_COUNT-1:0]      wb_req,
    output logic [`PRF_WR_COUNT-1:0]                  wb_ready,
    output prf_pkg::wb_bus_t [`PRF_BANK_COUNT-1:0]    wb_bus,
    output prf_pkg::complete_t [`PRF_BANK_COUNT-1:0]  complete,
    output prf_pkg::data_t [`PRF_BANK_COUNT-1:0]      ram_wdata
);

    import prf_pkg::*;

    logic [`PRF_WR_COUNT-1:0]                         req_valid;
    wb_req_t [`PRF_WR_COUNT-1:0]                      req_payload;
    logic [`PRF_WR_COUNT-1:0]                         grant_by_wr;
    logic [`PRF_BANK_COUNT-1:0][`PRF_WR_COUNT-1:0]    req_by_bank;
    logic [`PRF_BANK_COUNT-1:0][`PRF_WR_COUNT-1:0]    grant_by_bank;
    wb_bus_t [`PRF_BANK_COUNT-1:0]                    next_bus;
    complete_t [`PRF_BANK_COUNT-1:0]                  next_complete;
    data_t [`PRF_BANK_COUNT-1:0]                      next_wdata;

    // ------------------------------------------------------------------
    // holding and arbitration

    for (genvar w = 0; w < `PRF_WR_COUNT; w++) begin : g_hold
        req_hold #(.payload_t(wb_req_t)) u_hold (
            .CLK         (CLK),
            .nRST        (nRST),
            .in_valid    (wb_valid[w]),
            .in_payload  (wb_req[w]),
            .grant       (grant_by_wr[w]),
            .ready       (wb_ready[w]),
            .req_valid   (req_valid[w]),
            .req_payload (req_payload[w])
        );
    end

    for (genvar b = 0; b < `PRF_BANK_COUNT; b++) begin : g_arb
        bank_arbiter #(.N_REQ(`PRF_WR_COUNT)) u_arb (
            .CLK   (CLK),
            .nRST  (nRST),
            .req   (req_by_bank[b]),
            .grant (grant_by_bank[b])
        );
    end

    always_comb begin
        req_by_bank = '0;
        for (int w = 0; w < `PRF_WR_COUNT; w++) begin
            req_by_bank[req_payload[w].pr[`PRF_BANK_W-1:0]][w] = req_valid[w];
        end
    end

    // ------------------------------------------------------------------
    // one-hot mux of the winner per bank

    always_comb begin
        grant_by_wr = '0;
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            grant_by_wr |= grant_by_bank[b];
            next_bus[b].valid = |grant_by_bank[b];
            next_bus[b].upper_pr = '0;
            next_complete[b].valid = |grant_by_bank[b];
            next_complete[b].rob_index = '0;
            next_wdata[b] = '0;
            for (int w = 0; w < `PRF_WR_COUNT; w++) begin
                next_bus[b].upper_pr |= req_payload[w].pr[`PRF_PR_W-1:`PRF_BANK_W]
                    & {`PRF_UPPER_PR_W{grant_by_bank[b][w]}};
                next_complete[b].rob_index |= req_payload[w].rob_index
                    & {`PRF_ROB_W{grant_by_bank[b][w]}};
                next_wdata[b] |= req_payload[w].data & {`PRF_DATA_W{grant_by_bank[b][w]}};
            end
        end
        // PR 0 is bank 0 row 0, never written or announced
        if (next_bus[0].upper_pr == '0) begin
            next_bus[0].valid = 1'b0;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wb_bus   <= '0;
            complete <= '0;
        end else begin
            wb_bus   <= next_bus;
            complete <= next_complete;
        end
    end

    always_ff @(posedge CLK) begin
        ram_wdata <= next_wdata;
    end

    a_no_pr0_write: assert property (@(posedge CLK) disable iff (!nRST)
        !(wb_bus[0].valid && wb_bus[0].upper_pr == '0));

endmodule

/* verilog/prf.sv */
// ----------------------------------------------------------------------
// Banked physical register file, top level. Joins the read path, the
// writeback path and one RAM per bank. Requesters see valid/ready per
// requester; results come out per bank one cycle after the grant.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "prf_defines.svh"

module prf (
    input  logic                                      CLK,
    input  logic                                      nRST,
    input  logic [`PRF_WR_COUNT-1:0]                  wb_valid,
    input  prf_pkg::wb_req_t [`PRF_WR_COUNT-1:0]      wb_req,
    input  logic [`PRF_RR_COUNT-1:0]                  rd_valid,
    input  prf_pkg::rd_req_t [`PRF_RR_COUNT-1:0]      rd_req,
    output logic [`PRF_WR_COUNT-1:0]                  wb_ready,
    output prf_pkg::wb_bus_t [`PRF_BANK_COUNT-1:0]    wb_bus,
    output prf_pkg::complete_t [`PRF_BANK_COUNT-1:0]  complete,
    output logic [`PRF_RR_COUNT-1:0]                  rd_ready,
    output logic [`PRF_RR_COUNT-1:0]                  rd_ack,
    output prf_pkg::data_t [`PRF_BANK_COUNT-1:0]      rd_data
);

    import prf_pkg::*;

    upper_pr_t [`PRF_BANK_COUNT-1:0] rd_rindex;
    data_t [`PRF_BANK_COUNT-1:0]     ram_wdata;

    prf_read_path u_read_path (
        .CLK       (CLK),
        .nRST      (nRST),
        .rd_valid  (rd_valid),
        .rd_req    (rd_req),
        .rd_ready  (rd_ready),
        .rd_ack    (rd_ack),
        .rd_rindex (rd_rindex)
    );

    prf_wb_path u_wb_path (
        .CLK       (CLK),
        .nRST      (nRST),
        .wb_valid  (wb_valid),
        .wb_req    (wb_req),
        .wb_ready  (wb_ready),
        .wb_bus    (wb_bus),
        .complete  (complete),
        .ram_wdata (ram_wdata)
    );

    // write enable and row come straight from the announced bus
    for (genvar b = 0; b < `PRF_BANK_COUNT; b++) begin : g_bank
        bank_ram u_ram (
            .CLK    (CLK),
            .nRST   (nRST),
            .wen    (wb_bus[b].valid),
            .windex (wb_bus[b].upper_pr),
            .wdata  (ram_wdata[b]),
            .rindex (rd_rindex[b]),
            .rdata  (rd_data[b])
        );
    end

endmodule

/* verif/tb_prf.sv */
// ----------------------------------------------------------------------
// Directed testbench for the banked register file. Runs reset, single
// write/read, PR 0, parallel bank and bank conflict tests. Expected
// data comes from a reference register array, expected order from a
// round-robin winner model kept per bank.
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "prf_defines.svh"

module tb_prf;

    import prf_pkg::*;

    localparam int TIMEOUT = 20;

    logic                              CLK;
    logic                              nRST;
    logic [`PRF_WR_COUNT-1:0]          wb_valid;
    wb_req_t [`PRF_WR_COUNT-1:0]       wb_req;
    logic [`PRF_RR_COUNT-1:0]          rd_valid;
    rd_req_t [`PRF_RR_COUNT-1:0]       rd_req;
    logic [`PRF_WR_COUNT-1:0]          wb_ready;
    wb_bus_t [`PRF_BANK_COUNT-1:0]     wb_bus;
    complete_t [`PRF_BANK_COUNT-1:0]   complete;
    logic [`PRF_RR_COUNT-1:0]          rd_ready;
    logic [`PRF_RR_COUNT-1:0]          rd_ack;
    data_t [`PRF_BANK_COUNT-1:0]       rd_data;

    // reference state
    data_t       model [`PRF_PR_COUNT];
    int          last_wr [`PRF_BANK_COUNT];
    int          last_rd [`PRF_BANK_COUNT];
    logic [31:0] lfsr_state;

    prf u_dut (
        .CLK      (CLK),
        .nRST     (nRST),
        .wb_valid (wb_valid),
        .wb_req   (wb_req),
        .rd_valid (rd_valid),
        .rd_req   (rd_req),
        .wb_ready (wb_ready),
        .wb_bus   (wb_bus),
        .complete (complete),
        .rd_ready (rd_ready),
        .rd_ack   (rd_ack),
        .rd_data  (rd_data)
    );

    always #4 CLK = ~CLK;

    // ------------------------------------------------------------------
    // helpers

    // taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_bit()};
        end
        return value;
    endfunction

    function automatic int bank_of(input pr_t pr_num);
        return int'(pr_num[`PRF_BANK_W-1:0]);
    endfunction

    function automatic upper_pr_t row_of(input pr_t pr_num);
        return pr_num[`PRF_PR_W-1:`PRF_BANK_W];
    endfunction

    function automatic pr_t make_pr(input int row, input int bank);
        return {row[`PRF_UPPER_PR_W-1:0], bank[`PRF_BANK_W-1:0]};
    endfunction

    // first requester above the last winner, else the lowest one
    function automatic int next_winner(input logic [`PRF_WR_COUNT-1:0] reqs, input int last);
        for (int i = last + 1; i < `PRF_WR_COUNT; i++) begin
            if (reqs[i]) return i;
        end
        for (int i = 0; i < `PRF_WR_COUNT; i++) begin
            if (reqs[i]) return i;
        end
        return -1;
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at time %0t: %s, got %0h, expected %0h", $time, what, actual,
                     expected);
            $display("Some tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out after %0d cycles waiting for %s", TIMEOUT, what);
        $display("Some tests failed");
        $fatal(1, "wait timed out");
    endtask

    task automatic wait_complete(input int bank, output int cycles);
        cycles = 0;
        do begin
            @(negedge CLK);
            cycles++;
            if (cycles > TIMEOUT) report_timeout("a completion");
        end while (!complete[bank].valid);
    endtask

    task automatic wait_ack(input int r, output int cycles);
        cycles = 0;
        do begin
            @(negedge CLK);
            cycles++;
            if (cycles > TIMEOUT) report_timeout("a read ack");
        end while (!rd_ack[r]);
    endtask

    task automatic drive_write(input int w, input pr_t pr_num, input data_t value,
                               input rob_index_t rob);
        wb_valid[w]            <= 1'b1;
        wb_req[w].pr           <= pr_num;
        wb_req[w].data         <= value;
        wb_req[w].rob_index    <= rob;
    endtask

    task automatic drive_read(input int r, input pr_t pr_num);
        rd_valid[r]  <= 1'b1;
        rd_req[r].pr <= pr_num;
    endtask

    // bus and complete of the write's bank at mid-cycle
    task automatic check_write_report(input pr_t pr_num, input rob_index_t rob);
        int b;
        b = bank_of(pr_num);
        check_value(64'(complete[b].valid), 64'(1), "complete valid");
        check_value(64'(complete[b].rob_index), 64'(rob), "complete rob index");
        check_value(64'(wb_bus[b].valid), 64'(pr_num != '0), "wb_bus valid");
        if (pr_num != '0) begin
            check_value(64'(wb_bus[b].upper_pr), 64'(row_of(pr_num)), "wb_bus row");
        end
    endtask

    task automatic check_read_report(input int r, input pr_t pr_num);
        check_value(64'(rd_ack[r]), 64'(1), "rd_ack");
        check_value(64'(rd_data[bank_of(pr_num)]), 64'(model[pr_num]), "rd_data");
    endtask

    task automatic write_reg(input int w, input pr_t pr_num, input data_t value,
                             input rob_index_t rob);
        int cycles;
        @(posedge CLK);
        drive_write(w, pr_num, value, rob);
        @(negedge CLK);
        check_value(64'(wb_ready[w]), 64'(1), "wb_ready with no held request");
        @(posedge CLK);
        wb_valid[w] <= 1'b0;
        wait_complete(bank_of(pr_num), cycles);
        check_value(64'(cycles), 64'(1), "writeback latency");
        check_write_report(pr_num, rob);
        last_wr[bank_of(pr_num)] = w;
        if (pr_num != '0) model[pr_num] = value;
    endtask

    task automatic read_reg(input int r, input pr_t pr_num);
        int cycles;
        @(posedge CLK);
        drive_read(r, pr_num);
        @(negedge CLK);
        check_value(64'(rd_ready[r]), 64'(1), "rd_ready with no held request");
        @(posedge CLK);
        rd_valid[r] <= 1'b0;
        wait_ack(r, cycles);
        check_value(64'(cycles), 64'(1), "read latency");
        check_read_report(r, pr_num);
        last_rd[bank_of(pr_num)] = r;
    endtask

    // ------------------------------------------------------------------
    // tests

    task automatic test_reset_state();
        @(negedge CLK);
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            check_value(64'(wb_bus[b].valid), 64'(0), "wb_bus valid after reset");
            check_value(64'(complete[b].valid), 64'(0), "complete valid after reset");
        end
        check_value(64'(rd_ack), 64'(0), "rd_ack after reset");
        check_value(64'(wb_ready), 64'(3'b111), "wb_ready after reset");
        check_value(64'(rd_ready), 64'(3'b111), "rd_ready after reset");
        for (int p = 0; p < `PRF_PR_COUNT; p++) begin
            read_reg(p % `PRF_RR_COUNT, pr_t'(p));
        end
    endtask

    task automatic test_write_read();
        pr_t prs [8];
        for (int i = 0; i < 8; i++) begin
            prs[i] = make_pr(int'(random_bits(3)), i % `PRF_BANK_COUNT);
            if (prs[i] == '0) prs[i] = make_pr(1, 0);
            write_reg(i % `PRF_WR_COUNT, prs[i], random_bits(32), rob_index_t'(i));
        end
        for (int i = 0; i < 8; i++) begin
            read_reg((i + 1) % `PRF_RR_COUNT, prs[i]);
        end
    endtask

    task automatic test_pr_zero();
        write_reg(0, '0, random_bits(32), rob_index_t'(20));
        read_reg(1, '0);
    endtask

    task automatic test_parallel_banks();
        pr_t   prs [`PRF_WR_COUNT];
        data_t vals [`PRF_WR_COUNT];
        int    cycles;
        @(posedge CLK);
        // writer w goes to bank w+1
        for (int w = 0; w < `PRF_WR_COUNT; w++) begin
            prs[w]  = make_pr(w + 2, w + 1);
            vals[w] = random_bits(32);
            drive_write(w, prs[w], vals[w], rob_index_t'(8 + w));
        end
        @(negedge CLK);
        check_value(64'(wb_ready), 64'(3'b111), "wb_ready before parallel writes");
        @(posedge CLK);
        wb_valid <= '0;
        wait_complete(bank_of(prs[0]), cycles);
        check_value(64'(cycles), 64'(1), "parallel writeback latency");
        for (int w = 0; w < `PRF_WR_COUNT; w++) begin
            check_write_report(prs[w], rob_index_t'(8 + w));
            last_wr[bank_of(prs[w])] = w;
            model[prs[w]] = vals[w];
        end
        @(posedge CLK);
        for (int r = 0; r < `PRF_RR_COUNT; r++) begin
            drive_read(r, prs[r]);
        end
        @(negedge CLK);
        check_value(64'(rd_ready), 64'(3'b111), "rd_ready before parallel reads");
        @(posedge CLK);
        rd_valid <= '0;
        wait_ack(0, cycles);
        check_value(64'(cycles), 64'(1), "parallel read latency");
        check_value(64'(rd_ack), 64'(3'b111), "parallel read acks");
        for (int r = 0; r < `PRF_RR_COUNT; r++) begin
            check_read_report(r, prs[r]);
            last_rd[bank_of(prs[r])] = r;
        end
    endtask

    task automatic test_write_conflict();
        pr_t                      prs [`PRF_WR_COUNT];
        data_t                    vals [`PRF_WR_COUNT];
        logic [`PRF_WR_COUNT-1:0] pending;
        logic [`PRF_WR_COUNT-1:0] granted;
        int                       winner;
        int                       cycles;
        @(posedge CLK);
        for (int w = 0; w < `PRF_WR_COUNT; w++) begin
            prs[w]  = make_pr(2 * w + 1, 2);
            vals[w] = random_bits(32);
            drive_write(w, prs[w], vals[w], rob_index_t'(16 + w));
        end
        @(negedge CLK);
        check_value(64'(wb_ready), 64'(3'b111), "wb_ready before write conflict");
        @(posedge CLK);
        wb_valid <= '0;
        pending = '1;
        granted = '0;
        // one report per cycle while losers stay held
        for (int k = 0; k < `PRF_WR_COUNT; k++) begin
            winner = next_winner(pending, last_wr[2]);
            wait_complete(2, cycles);
            check_value(64'(cycles), 64'(1), "cycles between conflict reports");
            check_write_report(prs[winner], rob_index_t'(16 + winner));
            pending[winner] = 1'b0;
            granted[winner] = 1'b1;
            last_wr[2] = winner;
            model[prs[winner]] = vals[winner];
            check_value(64'(wb_ready), 64'(granted), "wb_ready during write conflict");
        end
        // readers 2, 0, 1 so the read conflict starts mid rotation
        for (int w = 0; w < `PRF_WR_COUNT; w++) begin
            read_reg((w + 2) % `PRF_RR_COUNT, prs[w]);
        end
    endtask

    task automatic test_read_conflict();
        pr_t                      prs [`PRF_RR_COUNT];
        logic [`PRF_RR_COUNT-1:0] pending;
        logic [`PRF_RR_COUNT-1:0] granted;
        logic [`PRF_RR_COUNT-1:0] onehot;
        int                       winner;
        int                       cycles;
        @(posedge CLK);
        for (int r = 0; r < `PRF_RR_COUNT; r++) begin
            prs[r] = make_pr(2 * (2 - r) + 1, 2);
            drive_read(r, prs[r]);
        end
        @(negedge CLK);
        check_value(64'(rd_ready), 64'(3'b111), "rd_ready before read conflict");
        @(posedge CLK);
        rd_valid <= '0;
        pending = '1;
        granted = '0;
        for (int k = 0; k < `PRF_RR_COUNT; k++) begin
            winner = next_winner(pending, last_rd[2]);
            wait_ack(winner, cycles);
            check_value(64'(cycles), 64'(1), "cycles between conflict acks");
            onehot = '0;
            onehot[winner] = 1'b1;
            check_value(64'(rd_ack), 64'(onehot), "single ack per cycle");
            check_read_report(winner, prs[winner]);
            pending[winner] = 1'b0;
            granted[winner] = 1'b1;
            last_rd[2] = winner;
            check_value(64'(rd_ready), 64'(granted), "rd_ready during read conflict");
        end
    endtask

    // ------------------------------------------------------------------
    // main sequence

    initial begin
        CLK        = 1'b0;
        nRST       = 1'b0;
        wb_valid   = '0;
        wb_req     = '0;
        rd_valid   = '0;
        rd_req     = '0;
        lfsr_state = 32'hf8f8;
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            last_wr[b] = -1;
            last_rd[b] = -1;
        end
        for (int p = 0; p < `PRF_PR_COUNT; p++) begin
            model[p] = '0;
        end
        repeat (4) @(posedge CLK);
        nRST <= 1'b1;

        test_reset_state();
        test_write_read();
        test_pr_zero();
        test_parallel_banks();
        test_write_conflict();
        test_read_conflict();

        $display("All tests passed");
        $finish;
    end

endmodule

/* build.f */
+incdir+verilog
verilog/prf_pkg.sv
verilog/req_hold.sv
verilog/bank_arbiter.sv
verilog/bank_ram.sv
verilog/prf_read_path.sv
verilog/prf_wb_path.sv
verilog/prf.sv
verif/tb_prf.sv

/* Makefile */
# Verilator build and run for the register file testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_prf
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
